// ==== Makefile ====
# Verilator flow for the vector control path.
# make lint | make sim | make clean, variables can be set on the command line.

VERILATOR  ?= verilator
TOP        ?= tb_vctrl_top
RTL_TOP    ?= vctrl_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

FAIL_MSG   := tests failed
PASS_MSG   := all tests passed
SOURCES    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dpram.sv ====
// Simple dual-port RAM for the control registers.
// One write port and one read port on a single clock. The read is
// registered and only updates when rd_en is high; a read of the address
// being written at the same edge returns the old contents.

`timescale 1ns/1ps

module dpram (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [vctrl_pkg::CTRL_ADDR_W-1:0]   wr_addr,
    input  logic [vctrl_pkg::CTRL_WIDTH-1:0]    wr_data,
    input  logic                                rd_en,
    input  logic [vctrl_pkg::CTRL_ADDR_W-1:0]   rd_addr,
    output logic [vctrl_pkg::CTRL_WIDTH-1:0]    rd_data
);

    // storage, contents undefined until written
    logic [vctrl_pkg::CTRL_WIDTH-1:0] mem [vctrl_pkg::NUM_CTRL_REGS];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, samples mem before this edge's write lands
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];          // old data on collision
        end
    end

endmodule

// ==== sources.f ====
vctrl_pkg.sv
vinstr_pkg.sv
dpram.sv
vctrl_decoder.sv
vregfile_control.sv
velem_sequencer.sv
vctrl_top.sv
vctrl_checker.sv
tb_vctrl_top.sv

// ==== tb_vctrl_top.sv ====
// Directed testbench for the vector control path top level.
// Covers reset values, register write and read back, the SETVL clamp,
// a masked element sequence and starts issued while busy.

`timescale 1ns/1ps

module tb_vctrl_top;

    localparam time CLK_PERIOD  = 100ns;
    localparam time DRIVE_DELAY = 10ns;
    localparam int  WAIT_LIMIT  = 20;     // cycles allowed for a strobe
    localparam int  MAX_CYCLES  = 3000;   // tests run about 270 cycles

    logic                               clk;
    logic                               resetn;
    logic                               instr_valid;
    logic [vinstr_pkg::INSTR_WIDTH-1:0] instr;
    logic [vctrl_pkg::CTRL_WIDTH-1:0]   scalar_data;
    logic                               result_valid;
    logic [vctrl_pkg::CTRL_WIDTH-1:0]   result_data;
    logic                               elem_valid;
    logic [vctrl_pkg::ELEM_IDX_W-1:0]   elem_idx;
    logic                               elem_active;
    logic                               busy;

    logic [31:0] lfsr_state = 32'h3d504adc;
    logic [31:0] shadow [vctrl_pkg::NUM_CTRL_REGS];   // expected register contents
    int          cycle_count = 0;

    vctrl_top i_vctrl_top (
        .clk          (clk),
        .resetn       (resetn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .scalar_data  (scalar_data),
        .result_valid (result_valid),
        .result_data  (result_data),
        .elem_valid   (elem_valid),
        .elem_idx     (elem_idx),
        .elem_active  (elem_active),
        .busy         (busy)
    );

    bind vctrl_top vctrl_checker i_vctrl_checker (
        .clk          (clk),
        .resetn       (resetn),
        .instr_valid  (instr_valid),
        .opcode       (instr[vinstr_pkg::OPCODE_MSB:vinstr_pkg::OPCODE_LSB]),
        .result_valid (result_valid),
        .elem_valid   (elem_valid),
        .elem_idx     (elem_idx),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (i_vctrl_top.i_vctrl_checker.fail_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("timeout, run exceeded %0d cycles", MAX_CYCLES));
        end
    end

    // ************************************************************
    // helpers
    // ************************************************************
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic drive_instr(input vinstr_pkg::vop_t op,
                               input logic [vctrl_pkg::CTRL_ADDR_W-1:0] reg_num,
                               input logic [31:0] operand);
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b1;
        instr       = '0;
        instr[vinstr_pkg::OPCODE_MSB:vinstr_pkg::OPCODE_LSB] = op;
        instr[vinstr_pkg::REG_MSB:vinstr_pkg::REG_LSB]       = reg_num;
        scalar_data = operand;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b0;
        instr       = '0;
        scalar_data = '0;
    endtask

    task automatic wait_result(input string name, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!result_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run({name, ": result_valid never came after the read"});
            end
            @(negedge clk);
        end
        data = result_data;
    endtask

    task automatic read_check(input string name,
                              input logic [vctrl_pkg::CTRL_ADDR_W-1:0] reg_num,
                              input logic [31:0] expected);
        logic [31:0] data;
        drive_instr(vinstr_pkg::VOP_MFC, reg_num, '0);
        drive_idle();
        wait_result(name, data);
        check_value(name, expected, data);
    endtask

    // issues VSTART and follows the sequence until busy drops
    task automatic watch_sequence(input string name, input int exp_len,
                                  input logic [31:0] mask, input int restart_at);
        int count;
        int waited;
        count  = 0;
        waited = 0;
        drive_instr(vinstr_pkg::VOP_VSTART, '0, '0);
        drive_idle();
        @(negedge clk);
        while (!busy) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run({name, ": busy never rose after VSTART"});
            end
            drive_idle();
            @(negedge clk);
        end
        waited = 0;
        while (busy) begin
            if (elem_valid) begin
                check_value({name, " elem_idx"}, count, elem_idx);
                check_value({name, " elem_active"}, mask[count % vctrl_pkg::CTRL_WIDTH],
                            elem_active);
                count++;
            end
            waited++;
            if (waited > exp_len + WAIT_LIMIT) begin
                abort_run({name, ": element sequence never ended"});
            end
            if (count == restart_at) begin
                drive_instr(vinstr_pkg::VOP_VSTART, '0, '0);   // lands mid-sequence
                restart_at = -1;
            end else begin
                drive_idle();
            end
            @(negedge clk);
        end
        check_value({name, " element count"}, exp_len, count);
        check_value({name, " elem_valid at end"}, 0, elem_valid);
        repeat (3) begin
            drive_idle();
            @(negedge clk);
            check_value({name, " busy after end"}, 0, busy);
        end
    endtask

    // ************************************************************
    // tests
    // ************************************************************
    task automatic test_reset_values();
        @(negedge clk);
        check_value("reset result_valid", 0, result_valid);
        check_value("reset elem_valid", 0, elem_valid);
        check_value("reset busy", 0, busy);
        watch_sequence("reset vstart", 0, '1, -1);   // vl resets to zero
    endtask

    task automatic test_write_read();
        logic [31:0] data;
        for (int r = 1; r <= 30; r++) begin
            data = take_bits(32);
            shadow[r] = data;
            drive_instr(vinstr_pkg::VOP_MTC, vctrl_pkg::CTRL_ADDR_W'(r), data);
        end
        drive_idle();
        for (int r = 1; r <= 30; r++) begin
            read_check($sformatf("write_read reg %0d", r), vctrl_pkg::CTRL_ADDR_W'(r),
                       shadow[r]);
        end
        // write then read the same register on consecutive cycles
        data = take_bits(32);
        shadow[12] = data;
        drive_instr(vinstr_pkg::VOP_MTC, 5'd12, data);
        read_check("write_read back to back", 5'd12, shadow[12]);
        // two reads in a row give two results in a row
        drive_instr(vinstr_pkg::VOP_MFC, 5'd3, '0);
        drive_instr(vinstr_pkg::VOP_MFC, 5'd4, '0);
        drive_idle();
        wait_result("write_read pair first", data);
        check_value("write_read pair first", shadow[3], data);
        @(negedge clk);
        check_value("write_read pair valid", 1, result_valid);
        check_value("write_read pair second", shadow[4], result_data);
    endtask

    task automatic test_setvl_clamp();
        logic [31:0] operand [3];
        logic [31:0] bits;
        logic [31:0] expected;
        bits = take_bits(6);
        operand[0] = bits;                            // below the limit
        operand[1] = vctrl_pkg::MAX_VL;
        bits = take_bits(20);
        operand[2] = vctrl_pkg::MAX_VL + 1 + bits;    // above the limit
        for (int i = 0; i < 3; i++) begin
            expected = (operand[i] < vctrl_pkg::MAX_VL) ? operand[i] : vctrl_pkg::MAX_VL;
            drive_instr(vinstr_pkg::VOP_SETVL, '0, operand[i]);
            drive_idle();
            read_check($sformatf("setvl_clamp case %0d", i), vctrl_pkg::VL_REG, expected);
        end
    endtask

    task automatic test_masked_sequence();
        logic [31:0] mask;
        mask = take_bits(32);
        drive_instr(vinstr_pkg::VOP_MTC, vctrl_pkg::MASK_REG, mask);
        drive_instr(vinstr_pkg::VOP_SETVL, '0, 32'd40);
        drive_idle();
        watch_sequence("masked_sequence", 40, mask, -1);
    endtask

    task automatic test_start_while_busy();
        logic [31:0] mask;
        mask = take_bits(32);
        drive_instr(vinstr_pkg::VOP_MTC, vctrl_pkg::MASK_REG, mask);
        drive_instr(vinstr_pkg::VOP_SETVL, '0, 32'd20);
        drive_idle();
        watch_sequence("start_while_busy", 20, mask, 5);
        watch_sequence("start_after_idle", 20, mask, -1);
    endtask

    initial begin
        resetn      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        scalar_data = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;

        test_reset_values();
        test_write_read();
        test_setvl_clamp();
        test_masked_sequence();
        test_start_while_busy();

        if (i_vctrl_top.i_vctrl_checker.fail_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== vctrl_checker.sv ====
// Concurrent assertions on the vector control path top level.
// Bound onto vctrl_top by the testbench and reports through $error only.

`timescale 1ns/1ps

module vctrl_checker (
    input logic                                clk,
    input logic                                resetn,
    input logic                                instr_valid,
    input logic [3:0]                          opcode,
    input logic                                result_valid,
    input logic                                elem_valid,
    input logic [vctrl_pkg::ELEM_IDX_W-1:0]    elem_idx,
    input logic                                busy
);

    logic mfc_issued;   // an MFC accepted at this edge
    int   fail_count = 0;   // failed assertions so far

    assign mfc_issued = instr_valid && (opcode == vinstr_pkg::VOP_MFC);

    // ********************************************************
    // sequencer outputs
    // ********************************************************
    a_reset_quiet: assert property (@(posedge clk) !resetn |=> (!busy && !elem_valid))
        else begin
            $error("busy or elem_valid high during reset");
            fail_count++;
        end

    a_elem_in_busy: assert property (@(posedge clk) disable iff (!resetn)
        elem_valid |-> busy)
        else begin
            $error("elem_valid outside a busy sequence");
            fail_count++;
        end

    a_idx_range: assert property (@(posedge clk) disable iff (!resetn)
        elem_valid |-> (elem_idx < vctrl_pkg::ELEM_IDX_W'(vctrl_pkg::MAX_VL)))
        else begin
            $error("elem_idx beyond MAX_VL");
            fail_count++;
        end

    // ********************************************************
    // read results
    // ********************************************************
    // result_valid trails the MFC by two edges
    a_result_pairs: assert property (@(posedge clk) disable iff (!resetn)
        (result_valid && $past(result_valid)) |-> ($past(mfc_issued, 2) && $past(mfc_issued, 3)))
        else begin
            $error("result_valid on consecutive cycles without back to back reads");
            fail_count++;
        end

endmodule

// ==== vctrl_decoder.sv ====
// Control instruction decoder.
// Takes one instruction per cycle and turns it into registered write or
// read strobes for the control register file, or a start pulse for the
// element sequencer. All outputs appear the cycle after the instruction.

`timescale 1ns/1ps

module vctrl_decoder (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   instr_valid,
    input  logic [vinstr_pkg::INSTR_WIDTH-1:0]     instr,
    input  logic [vctrl_pkg::CTRL_WIDTH-1:0]       scalar_data,
    output logic                                   c_we,
    output logic [vctrl_pkg::CTRL_ADDR_W-1:0]      c_reg,
    output logic [vctrl_pkg::CTRL_WIDTH-1:0]       c_writedatain,
    output logic                                   a_en,
    output logic [vctrl_pkg::CTRL_ADDR_W-1:0]      a_reg,
    output logic                                   start
);

    // ********************************************************
    // field extraction
    // ********************************************************
    vinstr_pkg::vop_t                  opcode;
    logic [vctrl_pkg::CTRL_ADDR_W-1:0] reg_field;
    logic [vctrl_pkg::CTRL_WIDTH-1:0]  vl_clamped;

    assign opcode    = vinstr_pkg::vop_t'(instr[vinstr_pkg::OPCODE_MSB:vinstr_pkg::OPCODE_LSB]);
    assign reg_field = instr[vinstr_pkg::REG_MSB:vinstr_pkg::REG_LSB];

    // every write that lands in vl goes through this clamp, so the
    // sequencer can rely on vl never exceeding MAX_VL
    assign vl_clamped = (scalar_data > vctrl_pkg::CTRL_WIDTH'(vctrl_pkg::MAX_VL)) ?
                        vctrl_pkg::CTRL_WIDTH'(vctrl_pkg::MAX_VL) : scalar_data;

    // ********************************************************
    // registered actions
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            c_we  <= 1'b0;
            a_en  <= 1'b0;
            start <= 1'b0;
        end else begin
            c_we  <= 1'b0;                    // strobes default low
            a_en  <= 1'b0;
            start <= 1'b0;
            if (instr_valid) begin
                case (opcode)
                    vinstr_pkg::VOP_MTC: begin
                        c_we <= 1'b1;
                    end
                    vinstr_pkg::VOP_MFC: begin
                        a_en <= 1'b1;
                    end
                    vinstr_pkg::VOP_SETVL: begin
                        c_we <= 1'b1;
                    end
                    vinstr_pkg::VOP_VSTART: begin
                        start <= 1'b1;
                    end
                    default: ;                // nop and unknown opcodes
                endcase
            end
        end
    end

    // payload, only meaningful under the strobes above
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            a_reg <= reg_field;
            if (opcode == vinstr_pkg::VOP_SETVL) begin
                c_reg         <= vctrl_pkg::VL_REG;
                c_writedatain <= vl_clamped;
            end else begin
                c_reg         <= reg_field;
                c_writedatain <= (reg_field == vctrl_pkg::VL_REG) ? vl_clamped : scalar_data;
            end
        end
    end

endmodule

// ==== vctrl_pkg.sv ====
// Control register architecture of the vector control path.
// Sizes, special register numbers and reset values shared by the
// register file, the decoder and the element sequencer.

package vctrl_pkg;

    // ********************************************************
    // register file geometry
    // ********************************************************
    localparam int unsigned CTRL_WIDTH    = 32;   // control word width
    localparam int unsigned NUM_CTRL_REGS = 32;
    localparam int unsigned CTRL_ADDR_W   = 5;    // register number width

    // special registers kept in flops as well as in the RAM
    localparam logic [CTRL_ADDR_W-1:0] VL_REG   = 5'd0;
    localparam logic [CTRL_ADDR_W-1:0] MASK_REG = 5'd31;

    // ********************************************************
    // vector length and element indexing
    // ********************************************************
    localparam int unsigned MAX_VL     = 64;      // largest legal vl
    localparam int unsigned ELEM_IDX_W = 7;       // reaches MAX_VL itself
    localparam int unsigned MASK_IDX_W = $clog2(CTRL_WIDTH);  // bit select in mask

    // reset values
    localparam logic [ELEM_IDX_W-1:0] VL_RESET   = '0;
    localparam logic [CTRL_WIDTH-1:0] MASK_RESET = '1;  // all elements active

endpackage

// ==== vctrl_top.sv ====
// Top level of the vector control path.
// Connects the instruction decoder to the control register file and the
// element sequencer. Read results and the element stream leave as plain
// strobes with no back-pressure.

`timescale 1ns/1ps

module vctrl_top (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                instr_valid,
    input  logic [vinstr_pkg::INSTR_WIDTH-1:0]  instr,
    input  logic [vctrl_pkg::CTRL_WIDTH-1:0]    scalar_data,
    output logic                                result_valid,
    output logic [vctrl_pkg::CTRL_WIDTH-1:0]    result_data,
    output logic                                elem_valid,
    output logic [vctrl_pkg::ELEM_IDX_W-1:0]    elem_idx,
    output logic                                elem_active,
    output logic                                busy
);

    // ********************************************************
    // internal wires
    // ********************************************************
    logic                                c_we;
    logic [vctrl_pkg::CTRL_ADDR_W-1:0]   c_reg;
    logic [vctrl_pkg::CTRL_WIDTH-1:0]    c_writedatain;
    logic                                a_en;
    logic [vctrl_pkg::CTRL_ADDR_W-1:0]   a_reg;
    logic                                start;
    logic [vctrl_pkg::ELEM_IDX_W-1:0]    vl;
    logic [vctrl_pkg::CTRL_WIDTH-1:0]    matmul_masks;

    // ********************************************************
    // instances
    // ********************************************************
    vctrl_decoder i_vctrl_decoder (
        .clk           (clk),
        .resetn        (resetn),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .scalar_data   (scalar_data),
        .c_we          (c_we),
        .c_reg         (c_reg),
        .c_writedatain (c_writedatain),
        .a_en          (a_en),
        .a_reg         (a_reg),
        .start         (start)
    );

    vregfile_control i_vregfile_control (
        .clk           (clk),
        .resetn        (resetn),
        .a_reg         (a_reg),
        .a_en          (a_en),
        .c_reg         (c_reg),
        .c_writedatain (c_writedatain),
        .c_we          (c_we),
        .a_readdataout (result_data),     // registered read data
        .a_valid       (result_valid),
        .vl            (vl),
        .matmul_masks  (matmul_masks)
    );

    velem_sequencer i_velem_sequencer (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .vl           (vl),
        .matmul_masks (matmul_masks),
        .elem_valid   (elem_valid),
        .elem_idx     (elem_idx),
        .elem_active  (elem_active),
        .busy         (busy)
    );

endmodule

// ==== velem_sequencer.sv ====
// Vector element sequencer.
// A start pulse while idle latches vl and then walks elements 0 to vl-1,
// one per cycle. Each element is marked active from the mask bit at its
// index modulo the mask width; the mask is read live, not latched.
// Starts that arrive while a sequence runs are dropped.

`timescale 1ns/1ps

module velem_sequencer (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                start,
    input  logic [vctrl_pkg::ELEM_IDX_W-1:0]    vl,
    input  logic [vctrl_pkg::CTRL_WIDTH-1:0]    matmul_masks,
    output logic                                elem_valid,
    output logic [vctrl_pkg::ELEM_IDX_W-1:0]    elem_idx,
    output logic                                elem_active,
    output logic                                busy
);

    logic [vctrl_pkg::ELEM_IDX_W-1:0] len;        // latched vl
    logic [vctrl_pkg::ELEM_IDX_W-1:0] next_idx;   // next element to emit

    // ********************************************************
    // sequence control
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy       <= 1'b0;
            elem_valid <= 1'b0;
            next_idx   <= '0;
        end else if (!busy) begin
            elem_valid <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                next_idx <= '0;
            end
        end else if (next_idx == len) begin
            // last element, if any, has already gone out
            busy       <= 1'b0;
            elem_valid <= 1'b0;
        end else begin
            elem_valid <= 1'b1;
            next_idx   <= next_idx + 1'b1;
        end
    end

    // length and index payload
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            len <= vl;
        end
        if (busy && (next_idx != len)) begin
            elem_idx <= next_idx;
        end
    end

    // ********************************************************
    // mask lookup
    // ********************************************************
    // live mask, so a mask write mid-sequence hits later elements
    assign elem_active = matmul_masks[elem_idx[vctrl_pkg::MASK_IDX_W-1:0]];

endmodule

// ==== vinstr_pkg.sv ====
// Encoding of the control instructions accepted by the decoder.
// Holds the instruction width, field positions and the opcode type.

package vinstr_pkg;

    // ********************************************************
    // instruction word layout
    // ********************************************************
    localparam int unsigned INSTR_WIDTH = 32;

    // opcode in the top nibble
    localparam int unsigned OPCODE_MSB = 31;
    localparam int unsigned OPCODE_LSB = 28;

    // control register number in the low bits
    localparam int unsigned REG_MSB = 4;
    localparam int unsigned REG_LSB = 0;

    // ********************************************************
    // opcodes
    // ********************************************************
    // values not listed here decode as a nop
    typedef enum logic [3:0] {
        VOP_NOP    = 4'h0,  // no action
        VOP_MTC    = 4'h1,  // scalar operand -> control reg
        VOP_MFC    = 4'h2,  // control reg -> scalar result
        VOP_SETVL  = 4'h3,  // vl <= min(operand, MAX_VL)
        VOP_VSTART = 4'h4   // launch element sequence
    } vop_t;

endpackage

// ==== vregfile_control.sv ====
// Control register file of the vector control path.
// All control registers live in a dual-port RAM with read port a and
// write port c. vl and the element mask are also kept in flops so the
// sequencer sees them as levels without going through the RAM.
// a_valid marks the cycle that carries a_readdataout.

`timescale 1ns/1ps

module vregfile_control (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic [vctrl_pkg::CTRL_ADDR_W-1:0]   a_reg,
    input  logic                                a_en,
    input  logic [vctrl_pkg::CTRL_ADDR_W-1:0]   c_reg,
    input  logic [vctrl_pkg::CTRL_WIDTH-1:0]    c_writedatain,
    input  logic                                c_we,
    output logic [vctrl_pkg::CTRL_WIDTH-1:0]    a_readdataout,
    output logic                                a_valid,
    output logic [vctrl_pkg::ELEM_IDX_W-1:0]    vl,
    output logic [vctrl_pkg::CTRL_WIDTH-1:0]    matmul_masks
);

    // ********************************************************
    // register storage
    // ********************************************************
    dpram i_dpram (
        .clk     (clk),
        .wr_en   (c_we),
        .wr_addr (c_reg),
        .wr_data (c_writedatain),
        .rd_en   (a_en),
        .rd_addr (a_reg),
        .rd_data (a_readdataout)
    );

    // read data comes one edge after a_en
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_valid <= 1'b0;
        end else begin
            a_valid <= a_en;
        end
    end

    // ********************************************************
    // special registers
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            vl           <= vctrl_pkg::VL_RESET;
            matmul_masks <= vctrl_pkg::MASK_RESET;
        end else if (c_we) begin
            if (c_reg == vctrl_pkg::VL_REG) begin
                // decoder has already clamped to MAX_VL
                vl <= c_writedatain[vctrl_pkg::ELEM_IDX_W-1:0];
            end else if (c_reg == vctrl_pkg::MASK_REG) begin
                matmul_masks <= c_writedatain;
            end
        end
    end

endmodule
